// ==== logic/vga_timing_pkg.sv ====
// VGA timing constants
// 640x480 at 60 Hz with an 800x525 raster, visible region first in
// every line and every frame, then front porch, sync and back porch
package vga_timing_pkg;

  // counter widths
  localparam int x_w = 10;
  localparam int y_w = 10;

  // horizontal line in pixel clocks
  localparam logic [x_w-1:0] h_visible = 10'd640;
  localparam logic [x_w-1:0] h_front   = 10'd16;
  localparam logic [x_w-1:0] h_sync    = 10'd96;
  localparam logic [x_w-1:0] h_back    = 10'd48;
  // 800 clocks per line
  localparam logic [x_w-1:0] h_total   = h_visible + h_front + h_sync + h_back;

  // vertical frame in lines
  localparam logic [y_w-1:0] v_visible = 10'd480;
  localparam logic [y_w-1:0] v_front   = 10'd10;
  localparam logic [y_w-1:0] v_sync    = 10'd2;
  localparam logic [y_w-1:0] v_back    = 10'd33;
  // 525 lines per frame
  localparam logic [y_w-1:0] v_total   = v_visible + v_front + v_sync + v_back;

  // cycles from a counter value to the output pins
  //   one for the synchronous RAM read
  //   one for the output register
  localparam int out_latency = 2;

endpackage

// ==== logic/vga_pixel_pkg.sv ====
// VGA pixel and memory definitions
// framebuffer geometry, sprite geometry widths and the 8-bit pixel
// word that is both a raw memory byte and an RGB332 colour
package vga_pixel_pkg;

  // 640 * 480 = 307200 words, 19 address bits
  localparam int fb_addr_w = 19;
  localparam logic [fb_addr_w-1:0] fb_depth = 19'd307200;

  // sprite position and size widths
  //   x covers 0..639, y covers 0..479
  localparam int spr_x_w = 10;
  localparam int spr_y_w = 9;

  // one pixel byte
  //   raw is what the memories store
  //   rgb is the colour decode
  //
  //   bit   7 6 5   4 3 2   1 0
  //         R R R   G G G   B B
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      // red in the top bits
      logic [2:0] red;
      logic [2:0] green;
      // blue only gets two bits
      logic [1:0] blue;
    } rgb;
  } pixel_t;

endpackage

// ==== logic/vga_sync_gen.sv ====
// VGA sync generator
// free-running pixel and line counters for an 800x525 raster, with
// registered hsync, vsync and active levels aligned to the counters
`timescale 1ns/1ps

module vga_sync_gen import vga_timing_pkg::*; (
  input  logic           iVGA_CLK,
  input  logic           iRST_n,
  output logic [x_w-1:0] x,
  output logic [y_w-1:0] y,
  output logic           hsync_n,
  output logic           vsync_n,
  output logic           active
);

  // sync pulse windows, start inclusive and end exclusive
  localparam logic [x_w-1:0] hs_start = h_visible + h_front;
  localparam logic [x_w-1:0] hs_end   = hs_start + h_sync;
  localparam logic [y_w-1:0] vs_start = v_visible + v_front;
  localparam logic [y_w-1:0] vs_end   = vs_start + v_sync;

  logic [x_w-1:0] x_next;
  logic [y_w-1:0] y_next;
  logic           line_end;
  logic           frame_end;

  assign line_end  = (x == h_total - 10'd1);
  assign frame_end = (y == v_total - 10'd1);

  // next counter values
  always_comb begin
    x_next = x + 10'd1;
    y_next = y;
    if (line_end) begin
      x_next = '0;
      // line counter steps once per line
      if (frame_end) begin
        y_next = '0;
      end else begin
        y_next = y + 10'd1;
      end
    end
  end

  // decode from the next values so the levels land with x and y
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      x       <= '0;
      y       <= '0;
      // levels as decoded for pixel (0,0)
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
      active  <= 1'b1;
    end else begin
      x       <= x_next;
      y       <= y_next;
      hsync_n <= !((x_next >= hs_start) && (x_next < hs_end));
      vsync_n <= !((y_next >= vs_start) && (y_next < vs_end));
      active  <= (x_next < h_visible) && (y_next < v_visible);
    end
  end

endmodule

// ==== logic/framebuffer.sv ====
// 8-bit framebuffer
// one byte per visible pixel, written through a strobe port with a
// one-cycle capture stage and read synchronously by the scan logic
`timescale 1ns/1ps

module framebuffer import vga_pixel_pkg::*; (
  input  logic                 iVGA_CLK,
  input  logic                 iRST_n,
  input  logic                 fb_we,
  input  logic [fb_addr_w-1:0] fb_waddr,
  input  pixel_t               fb_wdata,
  input  logic [fb_addr_w-1:0] fb_raddr,
  output pixel_t               fb_rdata
);

  // pixel store
  logic [7:0] mem [fb_depth];

  // captured write
  logic                 wr_pend;
  logic [fb_addr_w-1:0] wr_addr;
  pixel_t               wr_data;
  logic                 wr_take;

  // a strobe right behind an accepted one is dropped
  assign wr_take = fb_we && !wr_pend;

  // power-up image is all black
  initial begin
    for (int i = 0; i < int'(fb_depth); i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      wr_pend <= 1'b0;
    end else begin
      // pending lasts exactly one cycle
      wr_pend <= wr_take;
    end
  end

  always_ff @(posedge iVGA_CLK) begin
    if (wr_take) begin
      wr_addr <= fb_waddr;
      wr_data <= fb_wdata;
    end
  end

  // memory port, write one cycle after capture
  always_ff @(posedge iVGA_CLK) begin
    if (wr_pend && (wr_addr < fb_depth)) begin
      mem[wr_addr] <= wr_data.raw;
    end
  end

  // read port, one cycle of latency
  // addresses past the end only occur in blanking and read as black
  always_ff @(posedge iVGA_CLK) begin
    if (fb_raddr < fb_depth) begin
      fb_rdata.raw <= mem[fb_raddr];
    end else begin
      fb_rdata.raw <= '0;
    end
  end

endmodule

// ==== logic/scan_address_gen.sv ====
// Scan address generator
// walks the framebuffer in raster order and tracks the sprite
// rectangle, stepping the external sprite RAM address on each hit
`timescale 1ns/1ps

module scan_address_gen
  import vga_timing_pkg::*;
  import vga_pixel_pkg::*;
(
  input  logic                 iVGA_CLK,
  input  logic                 iRST_n,
  input  logic [x_w-1:0]       x,
  input  logic [y_w-1:0]       y,
  input  logic                 active,
  input  logic                 sprite_en,
  input  logic [spr_x_w-1:0]   sprite_x,
  input  logic [spr_x_w-1:0]   sprite_x_size,
  input  logic [spr_y_w-1:0]   sprite_y,
  input  logic [spr_y_w-1:0]   sprite_y_size,
  output logic [fb_addr_w-1:0] fb_raddr,
  output logic [fb_addr_w-1:0] spr_raddr,
  output logic                 spr_hit_q
);

  logic [fb_addr_w-1:0] line_base;
  logic                 line_end;
  logic                 frame_end;

  // sprite window limits, one bit wider so the sum cannot wrap
  logic [spr_x_w:0]     x_lim;
  logic [y_w-1:0]       y_lim;
  logic                 hit_x;
  logic                 hit_y;
  logic                 hit;

  assign line_end  = (x == h_total - 10'd1);
  assign frame_end = line_end && (y == v_total - 10'd1);

  // read address for the pixel under the counters
  assign fb_raddr = line_base + fb_addr_w'(x);

  // sprite hit, upper edges excluded
  assign x_lim = {1'b0, sprite_x} + {1'b0, sprite_x_size};
  assign y_lim = y_w'(sprite_y) + y_w'(sprite_y_size);
  assign hit_x = (x >= sprite_x) && ({1'b0, x} < x_lim);
  assign hit_y = (y >= y_w'(sprite_y)) && (y < y_lim);
  assign hit   = hit_x && hit_y;

  // line base steps by one line of pixels after each visible line
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      line_base <= '0;
    end else if (frame_end) begin
      line_base <= '0;
    end else if (line_end && (y < v_visible)) begin
      line_base <= line_base + fb_addr_w'(h_visible);
    end
  end

  // sprite address counts hits in raster order
  // only right while the sprite lies wholly on screen
  // steps even with the sprite disabled
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      spr_raddr <= '0;
    end else if (frame_end) begin
      spr_raddr <= '0;
    end else if (active && hit) begin
      spr_raddr <= spr_raddr + 19'd1;
    end
  end

  // select flag lines up with the RAM read data
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      spr_hit_q <= 1'b0;
    end else begin
      spr_hit_q <= hit && sprite_en;
    end
  end

endmodule

// ==== logic/color_out_stage.sv ====
// Colour output stage
// picks the sprite or framebuffer byte, expands RGB332 to 24-bit
// colour and delays sync and blank to stay aligned with the pixel
`timescale 1ns/1ps

module color_out_stage
  import vga_timing_pkg::*;
  import vga_pixel_pkg::*;
(
  input  logic       iVGA_CLK,
  input  logic       iRST_n,
  input  pixel_t     fb_rdata,
  input  pixel_t     spr_rdata,
  input  logic       spr_hit_q,
  input  logic       hsync_n,
  input  logic       vsync_n,
  input  logic       active,
  output logic [7:0] r_data,
  output logic [7:0] g_data,
  output logic [7:0] b_data,
  output logic       hs,
  output logic       vs,
  output logic       blank_n
);

  pixel_t                 pix;
  logic [out_latency-1:0] hs_pipe;
  logic [out_latency-1:0] vs_pipe;
  logic [out_latency-1:0] act_pipe;

  // sprite wins inside its rectangle
  assign pix = spr_hit_q ? spr_rdata : fb_rdata;

  // sync and active delay line, last stage drives the pins
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      hs_pipe  <= '1;
      vs_pipe  <= '1;
      act_pipe <= '0;
    end else begin
      hs_pipe  <= {hs_pipe[out_latency-2:0], hsync_n};
      vs_pipe  <= {vs_pipe[out_latency-2:0], vsync_n};
      act_pipe <= {act_pipe[out_latency-2:0], active};
    end
  end

  assign hs      = hs_pipe[out_latency-1];
  assign vs      = vs_pipe[out_latency-1];
  assign blank_n = act_pipe[out_latency-1];

  // bit replication so full scale maps to 8'hff
  // black outside the visible region
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      r_data <= '0;
      g_data <= '0;
      b_data <= '0;
    end else if (act_pipe[out_latency-2]) begin
      r_data <= {pix.rgb.red, pix.rgb.red, pix.rgb.red[2:1]};
      g_data <= {pix.rgb.green, pix.rgb.green, pix.rgb.green[2:1]};
      b_data <= {4{pix.rgb.blue}};
    end else begin
      r_data <= '0;
      g_data <= '0;
      b_data <= '0;
    end
  end

endmodule

// ==== logic/vga_sprite_top.sv ====
// VGA scan-out engine with one sprite overlay
// sync generator, framebuffer, scan address generator and colour
// stage; the sprite RAM sits outside and answers one cycle later
`timescale 1ns/1ps

module vga_sprite_top import vga_pixel_pkg::*; (
  input  logic                 iVGA_CLK,
  input  logic                 iRST_n,
  // framebuffer write strobe port
  input  logic                 fb_we,
  input  logic [fb_addr_w-1:0] fb_waddr,
  input  pixel_t               fb_wdata,
  // sprite placement
  input  logic                 sprite_en,
  input  logic [spr_x_w-1:0]   sprite_x,
  input  logic [spr_y_w-1:0]   sprite_y,
  input  logic [spr_x_w-1:0]   sprite_x_size,
  input  logic [spr_y_w-1:0]   sprite_y_size,
  // external sprite RAM, always reading
  output logic [fb_addr_w-1:0] spr_raddr,
  input  pixel_t               spr_rdata,
  // video out
  output logic [7:0]           r_data,
  output logic [7:0]           g_data,
  output logic [7:0]           b_data,
  output logic                 hs,
  output logic                 vs,
  output logic                 blank_n
);

  logic [9:0]           x;
  logic [9:0]           y;
  logic                 hsync_n;
  logic                 vsync_n;
  logic                 active;
  logic [fb_addr_w-1:0] fb_raddr;
  pixel_t               fb_rdata;
  logic                 spr_hit_q;

  vga_sync_gen u_sync (
    .iVGA_CLK (iVGA_CLK), .iRST_n (iRST_n),
    .x (x), .y (y), .hsync_n (hsync_n), .vsync_n (vsync_n), .active (active)
  );

  framebuffer u_fb (
    .iVGA_CLK (iVGA_CLK), .iRST_n (iRST_n),
    .fb_we (fb_we), .fb_waddr (fb_waddr), .fb_wdata (fb_wdata),
    .fb_raddr (fb_raddr), .fb_rdata (fb_rdata)
  );

  scan_address_gen u_scan (
    .iVGA_CLK (iVGA_CLK), .iRST_n (iRST_n),
    .x (x), .y (y), .active (active), .sprite_en (sprite_en),
    .sprite_x (sprite_x), .sprite_x_size (sprite_x_size),
    .sprite_y (sprite_y), .sprite_y_size (sprite_y_size),
    .fb_raddr (fb_raddr), .spr_raddr (spr_raddr), .spr_hit_q (spr_hit_q)
  );

  color_out_stage u_color (
    .iVGA_CLK (iVGA_CLK), .iRST_n (iRST_n),
    .fb_rdata (fb_rdata), .spr_rdata (spr_rdata), .spr_hit_q (spr_hit_q),
    .hsync_n (hsync_n), .vsync_n (vsync_n), .active (active),
    .r_data (r_data), .g_data (g_data), .b_data (b_data),
    .hs (hs), .vs (vs), .blank_n (blank_n)
  );

endmodule

// ==== dv/vga_sprite_assert.sv ====
// VGA output protocol checks
// bound into the top level, watches sync, blank and the sprite
// RAM address on every pixel clock
`timescale 1ns/1ps

module vga_sprite_assert import vga_pixel_pkg::*; (
  input logic                 iVGA_CLK,
  input logic                 iRST_n,
  input logic                 hs,
  input logic                 vs,
  input logic                 blank_n,
  input logic [fb_addr_w-1:0] spr_raddr
);

  // consecutive low cycles of hs, saturates
  logic [7:0] hs_low_run;

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      hs_low_run <= '0;
    end else if (hs) begin
      hs_low_run <= '0;
    end else if (hs_low_run != 8'hff) begin
      hs_low_run <= hs_low_run + 8'd1;
    end
  end

  // no sync pulse inside visible video
  sync_outside_video: assert property (
    @(posedge iVGA_CLK) disable iff (!iRST_n) blank_n |-> (hs && vs)
  ) else $error("hs or vs low while blank_n is high");

  // sprite reads stay inside one screen of pixels
  sprite_addr_range: assert property (
    @(posedge iVGA_CLK) disable iff (!iRST_n) spr_raddr < fb_depth
  ) else $error("sprite read address past the end of the screen");

  // hsync pulse is 96 clocks at most
  hsync_width: assert property (
    @(posedge iVGA_CLK) disable iff (!iRST_n) hs_low_run <= 8'd96
  ) else $error("hs low for more than 96 cycles");

endmodule

// ==== dv/tb_vga_sprite.sv ====
// Testbench for the VGA sprite engine
// writes a table of pixels in the first vertical blank, then checks
// sync timing, the sprite RAM address and every visible pixel of
// three frames at the pins, the last frame with the sprite overlay on
`timescale 1ns/1ps

module tb_vga_sprite;

  // raster at the pins
  localparam int h_pix        = 640;
  localparam int v_pix        = 480;
  localparam int line_cycles  = 800;
  localparam int frame_cycles = 800 * 525;
  // three frames plus margin
  localparam int max_cycles   = 3 * frame_cycles + 2000;

  // sprite rectangle
  localparam int spr_x0 = 100;
  localparam int spr_y0 = 50;
  localparam int spr_w  = 40;
  localparam int spr_h  = 30;

  localparam int n_writes = 16;

  logic        iVGA_CLK;
  logic        iRST_n;
  logic        fb_we;
  logic [18:0] fb_waddr;
  logic [7:0]  fb_wdata;
  logic        sprite_en;
  logic [9:0]  sprite_x;
  logic [8:0]  sprite_y;
  logic [9:0]  sprite_x_size;
  logic [8:0]  sprite_y_size;
  logic [18:0] spr_raddr;
  logic [7:0]  spr_rdata;
  logic [7:0]  r_data;
  logic [7:0]  g_data;
  logic [7:0]  b_data;
  logic        hs;
  logic        vs;
  logic        blank_n;

  // sprite RAM address as read, then delayed to line up with the pins
  logic [18:0] spr_addr_d1;
  logic [18:0] spr_addr_d2;

  // write table
  // a clear keep flag marks an entry issued right behind an accepted write
  int wr_x [n_writes] = '{0, 639, 5, 0, 639, 320, 320, 110,
                          139, 140, 99, 100, 100, 321, 321, 400};
  int wr_y [n_writes] = '{0, 0, 1, 479, 479, 240, 240, 60,
                          79, 79, 50, 50, 80, 240, 240, 300};
  bit wr_keep [n_writes] = '{1, 1, 0, 1, 1, 1, 0, 1,
                             1, 0, 1, 1, 1, 1, 1, 0};
  logic [7:0] wr_data [n_writes];

  // expected framebuffer image
  logic [7:0]  fb_model [h_pix * v_pix];
  logic [31:0] lfsr;
  int          error_count = 0;
  int          cycle_count = 0;

  // pin-side tracker
  int   frame_idx = 0;
  int   row = 0;
  int   col = 0;
  int   hs_period = 0;
  int   hs_low = 0;
  int   vs_period = 0;
  int   vs_low = 0;
  bit   hs_seen = 1'b0;
  bit   vs_seen = 1'b0;
  bit   seen_visible = 1'b0;
  bit   done = 1'b0;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  logic prev_blank = 1'b0;

  vga_sprite_top u_dut (
    .iVGA_CLK      (iVGA_CLK),
    .iRST_n        (iRST_n),
    .fb_we         (fb_we),
    .fb_waddr      (fb_waddr),
    .fb_wdata      (fb_wdata),
    .sprite_en     (sprite_en),
    .sprite_x      (sprite_x),
    .sprite_y      (sprite_y),
    .sprite_x_size (sprite_x_size),
    .sprite_y_size (sprite_y_size),
    .spr_raddr     (spr_raddr),
    .spr_rdata     (spr_rdata),
    .r_data        (r_data),
    .g_data        (g_data),
    .b_data        (b_data),
    .hs            (hs),
    .vs            (vs),
    .blank_n       (blank_n)
  );

  bind vga_sprite_top vga_sprite_assert u_assert (
    .iVGA_CLK (iVGA_CLK), .iRST_n (iRST_n), .hs (hs), .vs (vs),
    .blank_n (blank_n), .spr_raddr (spr_raddr)
  );

  initial begin
    iVGA_CLK = 1'b0;
    forever #20 iVGA_CLK = ~iVGA_CLK;
  end

  // sprite RAM with one cycle of latency
  // byte is the low address byte ^ 5a
  always @(posedge iVGA_CLK) begin
    spr_rdata   <= spr_raddr[7:0] ^ 8'h5a;
    spr_addr_d1 <= spr_raddr;
    // one more stage for the colour register
    spr_addr_d2 <= spr_addr_d1;
  end

  always @(posedge iVGA_CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: frame checks not finished after %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $fatal(1, "run stopped on timeout");
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // RGB332 to 24 bits by bit replication
  function automatic logic [23:0] expand_rgb332(input logic [7:0] p);
    return {p[7:5], p[7:5], p[7:6], p[4:2], p[4:2], p[4:3], {4{p[1:0]}}};
  endfunction

  function automatic bit in_sprite(input int px, input int py);
    return (px >= spr_x0) && (px < spr_x0 + spr_w) &&
           (py >= spr_y0) && (py < spr_y0 + spr_h);
  endfunction

  // sprite read in raster order from zero
  function automatic int sprite_offset(input int px, input int py);
    return (py - spr_y0) * spr_w + (px - spr_x0);
  endfunction

  // frame 0 is black and frame 1 shows the written image
  // frame 2 adds the sprite
  function automatic logic [23:0] expected_colour(input int frame, input int px,
                                                  input int py);
    logic [7:0] p;
    int         offs;
    p = 8'h00;
    if (frame >= 1) begin
      p = fb_model[py * h_pix + px];
    end
    if ((frame >= 2) && in_sprite(px, py)) begin
      offs = sprite_offset(px, py);
      p = offs[7:0] ^ 8'h5a;
    end
    return expand_rgb332(p);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s expected %0h got %0h (frame %0d x %0d y %0d)",
               $time, what, expected, actual, frame_idx, col, row);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // outputs sampled on the falling edge half a cycle after they move
  always @(negedge iVGA_CLK) begin
    if (iRST_n && !done) begin
      // hsync falls once per line and stays low 96 clocks
      if (prev_hs && !hs) begin
        if (hs_seen) begin
          check_value("hs period", 32'(line_cycles), 32'(hs_period));
        end
        hs_seen = 1'b1;
        hs_period = 0;
      end
      hs_period++;
      if (!hs) begin
        hs_low++;
      end
      if (!prev_hs && hs) begin
        check_value("hs low width", 32'd96, 32'(hs_low));
        hs_low = 0;
      end
      // vsync falls once per frame and stays low two lines
      if (prev_vs && !vs) begin
        if (vs_seen) begin
          check_value("vs period", 32'(frame_cycles), 32'(vs_period));
        end
        check_value("visible lines per frame", 32'(v_pix), 32'(row));
        vs_seen = 1'b1;
        vs_period = 0;
        row = 0;
        frame_idx++;
      end
      vs_period++;
      if (!vs) begin
        vs_low++;
      end
      if (!prev_vs && vs) begin
        check_value("vs low width", 32'(2 * line_cycles), 32'(vs_low));
        vs_low = 0;
      end
      if (blank_n) begin
        seen_visible = 1'b1;
        check_value("pixel colour", 32'(expected_colour(frame_idx, col, row)),
                    32'({r_data, g_data, b_data}));
        // address steps on every hit with or without the overlay
        if (in_sprite(col, row)) begin
          check_value("sprite address", 32'(sprite_offset(col, row)),
                      32'(spr_addr_d2));
        end
        col++;
      end else begin
        check_value("colour in blanking", 32'd0, 32'({r_data, g_data, b_data}));
        // idle levels until the first visible pixel
        if (!seen_visible) begin
          check_value("hs before first pixel", 32'd1, 32'(hs));
          check_value("vs before first pixel", 32'd1, 32'(vs));
        end
        if (prev_blank) begin
          check_value("visible pixels per line", 32'(h_pix), 32'(col));
          col = 0;
          row++;
          if ((frame_idx == 2) && (row == v_pix)) begin
            done = 1'b1;
          end
        end
      end
      prev_hs = hs;
      prev_vs = vs;
      prev_blank = blank_n;
    end
  end

  initial begin
    logic [7:0] b;
    iRST_n        = 1'b0;
    fb_we         = 1'b0;
    fb_waddr      = '0;
    fb_wdata      = 8'h00;
    sprite_en     = 1'b0;
    sprite_x      = 10'(spr_x0);
    sprite_y      = 9'(spr_y0);
    sprite_x_size = 10'(spr_w);
    sprite_y_size = 9'(spr_h);
    spr_rdata     = 8'h00;
    // data bytes take one LFSR step per bit
    lfsr = 32'h24a6;
    for (int i = 0; i < n_writes; i++) begin
      b = 8'h00;
      for (int k = 0; k < 8; k++) begin
        lfsr = lfsr_step(lfsr);
        b = {b[6:0], lfsr[0]};
      end
      wr_data[i] = b;
    end
    for (int i = 0; i < h_pix * v_pix; i++) begin
      fb_model[i] = 8'h00;
    end
    // dropped writes leave the earlier contents
    for (int i = 0; i < n_writes; i++) begin
      if (wr_keep[i]) begin
        fb_model[wr_y[i] * h_pix + wr_x[i]] = wr_data[i];
      end
    end

    // reset held for three cycles
    @(negedge iVGA_CLK);
    check_value("blank_n in reset", 32'd0, 32'(blank_n));
    check_value("hs in reset", 32'd1, 32'(hs));
    check_value("vs in reset", 32'd1, 32'(vs));
    check_value("colour in reset", 32'd0, 32'({r_data, g_data, b_data}));
    repeat (2) @(negedge iVGA_CLK);
    iRST_n = 1'b1;

    // table goes in during the vertical blank of frame 0
    wait (frame_idx == 1);
    for (int i = 0; i < n_writes; i++) begin
      if (wr_keep[i]) begin
        // idle cycle so the strobe is accepted
        @(negedge iVGA_CLK);
        fb_we = 1'b0;
      end
      @(negedge iVGA_CLK);
      fb_we    = 1'b1;
      fb_waddr = 19'(wr_y[i] * h_pix + wr_x[i]);
      fb_wdata = wr_data[i];
    end
    @(negedge iVGA_CLK);
    fb_we = 1'b0;

    // overlay on from frame 2
    wait (frame_idx == 2);
    @(negedge iVGA_CLK);
    sprite_en = 1'b1;

    wait (done);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
logic/vga_timing_pkg.sv
logic/vga_pixel_pkg.sv
logic/vga_sync_gen.sv
logic/framebuffer.sv
logic/scan_address_gen.sv
logic/color_out_stage.sv
logic/vga_sprite_top.sv
dv/vga_sprite_assert.sv
dv/tb_vga_sprite.sv

// ==== Makefile ====
# Verilator build and run for the VGA sprite engine

TOP := tb_vga_sprite
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
